// ==== lsu_pkg.sv ====
// Shared types and operation field positions for the load/store path, imported by all modules
package lsu_pkg;

  // Data and address words
  typedef logic [31:0] word_t;

  // Register numbers for the data bank and the pointer bank
  typedef logic [3:0] dreg_sel_t;
  typedef logic [2:0] preg_sel_t;

  // One bit per byte lane on the data bus
  typedef logic [3:0] byte_mask_t;

  // Encoded load/store operation as presented on the issue port
  typedef logic [14:0] ls_op_t;

  // Single-bit operation flags
  localparam int unsigned OP_STORE = 14;
  localparam int unsigned OP_PMOD  = 13;
  localparam int unsigned OP_WORD  = 12;
  localparam int unsigned OP_HALF  = 11;

  // Multi-bit operation fields, given as lowest bit and width
  localparam int unsigned OP_OFS_LSB  = 6;
  localparam int unsigned OP_OFS_W    = 5;
  localparam int unsigned OP_PSEL_LSB = 3;
  localparam int unsigned OP_PSEL_W   = 3;
  localparam int unsigned OP_DREG_LSB = 0;
  localparam int unsigned OP_DREG_W   = 3;

  // Any address bit at or above this one selects the peripheral space
  localparam int unsigned PERIPH_LSB = 20;

endpackage

// ==== data_ram.sv ====
// Word-wide synchronous data RAM with byte-lane write mask and registered read data
module data_ram
  import lsu_pkg::*;
#(
  parameter int unsigned RAM_WORDS = 256
)
(
  input  logic       CLK,
  input  logic       ram_cs,
  input  logic       bus_wr,
  input  byte_mask_t bus_mask,
  input  word_t      bus_addr,
  input  word_t      bus_wdata,
  output word_t      ram_rdata
);

  localparam int unsigned IDX_W = $clog2(RAM_WORDS);

  word_t            mem [RAM_WORDS];
  logic [IDX_W-1:0] idx;

  // Byte address bits 1 and 0 select lanes, the rest wrap around the array
  assign idx = IDX_W'(bus_addr[31:2] % RAM_WORDS);

  always_ff @(posedge CLK)
  begin
    if (ram_cs && bus_wr)
    begin
      // Only the masked lanes change
      for (int lane = 0; lane < 4; lane++)
      begin
        if (bus_mask[lane])
          mem[idx][8*lane +: 8] <= bus_wdata[8*lane +: 8];
      end
    end
    // Read data stays until the next read
    else if (ram_cs)
      ram_rdata <= mem[idx];
  end

endmodule

// ==== register_file.sv ====
// Data and pointer register banks with combinational reads, registered writes and host preload
module register_file
  import lsu_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,

  // Read ports used by the load/store unit
  input  preg_sel_t ptr_sel,
  output word_t     ptr,
  input  dreg_sel_t store_sel,
  output word_t     store_data,

  // Pointer update from a pointer-modify operation
  input  logic      ptr_upd_vld,
  input  preg_sel_t ptr_upd_sel,
  input  word_t     ptr_upd,

  // Load writeback
  input  logic      load_vld,
  input  dreg_sel_t load_sel,
  input  word_t     load_data,

  // Host preload, only used while nothing is in flight
  input  logic      host_wr,
  input  logic      host_sel_ptr,
  input  dreg_sel_t host_sel,
  input  word_t     host_data
);

  word_t dregs [16];
  word_t pregs [8];

  // Reads see the current bank contents in the same cycle
  assign ptr        = pregs[ptr_sel];
  assign store_data = dregs[store_sel];

  // Data bank, a load writeback takes priority over a host write
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      dregs <= '{default: '0};
    else if (load_vld)
      dregs[load_sel] <= load_data;
    else if (host_wr && !host_sel_ptr)
      dregs[host_sel] <= host_data;
  end

  // Pointer bank, the host addresses it with the low bits of its select
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      pregs <= '{default: '0};
    else if (ptr_upd_vld)
      pregs[ptr_upd_sel] <= ptr_upd;
    else if (host_wr && host_sel_ptr)
      pregs[preg_sel_t'(host_sel)] <= host_data;
  end

endmodule

// ==== ls_unit.sv ====
// Load/store unit that decodes issued operations, drives the no-wait data bus and returns loads
module ls_unit
  import lsu_pkg::*;
(
  input  logic       CLK,
  input  logic       RST,

  // Issue interface, at most one valid per cycle and never stalled
  input  logic       op_vld,
  input  ls_op_t     op,
  input  logic       dir_vld,
  input  logic       dir_store,
  input  dreg_sel_t  dir_sel,
  input  word_t      dir_addr,

  // Combinational register reads
  output preg_sel_t  ptr_sel,
  input  word_t      ptr,
  output dreg_sel_t  store_sel,
  input  word_t      store_data,

  // Pointer update and load writeback to the register banks
  output logic       ptr_upd_vld,
  output preg_sel_t  ptr_upd_sel,
  output word_t      ptr_upd,
  output logic       load_vld,
  output dreg_sel_t  load_sel,
  output word_t      load_data,

  // Data bus towards the RAM and the peripheral space
  output word_t      bus_addr,
  output logic       ram_cs,
  output logic       periph_sel,
  output logic       bus_wr,
  output byte_mask_t bus_mask,
  output word_t      bus_wdata,
  input  word_t      ram_rdata
);

  logic                issue;
  logic                is_store;
  logic                wr_en;
  logic                word_acc;
  logic                half_acc;
  logic                pmod;
  logic [OP_OFS_W-1:0] ofs;
  word_t               ofs_zx;
  word_t               ofs_sx;
  word_t               addr_next;
  word_t               addr;
  logic                periph;
  dreg_sel_t           data_reg;
  byte_mask_t          mask;
  word_t               wdata;

  // Load tag pipeline, index 0 is the bus stage and index 2 the writeback stage
  logic [2:0]          tag_vld;
  logic [2:0]          tag_word;
  logic [2:0]          tag_half;
  logic [1:0]          tag_lo [3];
  dreg_sel_t           tag_sel [3];
  word_t               rd_q;

  assign issue    = op_vld | dir_vld;
  assign is_store = dir_vld ? dir_store : op[OP_STORE];
  assign wr_en    = issue & is_store;

  // Direct transfers are always full words; word wins when both size bits are set
  assign word_acc = dir_vld | op[OP_WORD];
  assign half_acc = ~word_acc & op[OP_HALF];
  assign pmod     = op[OP_PMOD];

  // Both size bits set address the upper half of the data bank
  assign data_reg  = dir_vld ? dir_sel
                             : {op[OP_WORD] & op[OP_HALF], op[OP_DREG_LSB +: OP_DREG_W]};
  assign ptr_sel   = op[OP_PSEL_LSB +: OP_PSEL_W];
  assign store_sel = data_reg;

  // Offset scaled by the access size, unsigned for plain and signed for pointer modify
  assign ofs    = op[OP_OFS_LSB +: OP_OFS_W];
  assign ofs_zx = word_acc ? {25'd0, ofs, 2'b00} :
                  half_acc ? {26'd0, ofs, 1'b0}  : {27'd0, ofs};
  assign ofs_sx = word_acc ? {{25{ofs[4]}}, ofs, 2'b00} :
                  half_acc ? {{26{ofs[4]}}, ofs, 1'b0}  : {{27{ofs[4]}}, ofs};

  assign addr_next = ptr + (pmod ? ofs_sx : ofs_zx);

  // Post-increment uses the old pointer, pre-decrement uses the adjusted one
  assign addr = dir_vld            ? dir_addr :
                (pmod && !ofs_sx[31]) ? ptr   : addr_next;

  assign periph = |addr[31:PERIPH_LSB];

  // Lane mask from size and low address bits
  always_comb
  begin
    if (word_acc)
      mask = 4'b1111;
    else if (half_acc)
      mask = addr[1] ? 4'b1100 : 4'b0011;
    else
      mask = 4'b0001 << addr[1:0];
  end

  // Store data copied into every lane so the mask alone selects the target bytes
  assign wdata = word_acc ? store_data :
                 half_acc ? {2{store_data[15:0]}} : {4{store_data[7:0]}};

  // Bus control goes low on idle cycles
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      ram_cs      <= 1'b0;
      periph_sel  <= 1'b0;
      bus_wr      <= 1'b0;
      bus_mask    <= '0;
      ptr_upd_vld <= 1'b0;
    end
    else
    begin
      ram_cs      <= issue & ~periph;
      periph_sel  <= issue & periph;
      bus_wr      <= wr_en;
      bus_mask    <= issue ? mask : '0;
      ptr_upd_vld <= op_vld & pmod;
    end
  end

  // Address and pointer payload only move with a valid operation
  always_ff @(posedge CLK)
  begin
    bus_wdata <= wr_en ? wdata : '0;
    if (issue)
      bus_addr <= {addr[31:2], 2'b00};
    if (op_vld)
    begin
      ptr_upd_sel <= ptr_sel;
      ptr_upd     <= addr_next;
    end
  end

  // Only RAM loads return data, peripheral loads are dropped
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      tag_vld <= '0;
    else
      tag_vld <= {tag_vld[1:0], issue & ~is_store & ~periph};
  end

  always_ff @(posedge CLK)
  begin
    tag_word   <= {tag_word[1:0], word_acc};
    tag_half   <= {tag_half[1:0], half_acc};
    tag_lo[0]  <= addr[1:0];
    tag_lo[1]  <= tag_lo[0];
    tag_lo[2]  <= tag_lo[1];
    tag_sel[0] <= data_reg;
    tag_sel[1] <= tag_sel[0];
    tag_sel[2] <= tag_sel[1];
    // RAM read data is valid while the load sits in the second stage
    if (tag_vld[1])
      rd_q <= ram_rdata;
  end

  // Shift the addressed lane down and zero-extend
  always_comb
  begin
    if (tag_word[2])
      load_data = rd_q;
    else if (tag_half[2])
      load_data = tag_lo[2][1] ? {16'd0, rd_q[31:16]} : {16'd0, rd_q[15:0]};
    else
      load_data = {24'd0, rd_q[{tag_lo[2], 3'b000} +: 8]};
  end

  assign load_vld = tag_vld[2];
  assign load_sel = tag_sel[2];

endmodule

// ==== lsu_top.sv ====
// Top level of the load/store path, connecting the unit, the register banks and the data RAM
module lsu_top
  import lsu_pkg::*;
#(
  parameter int unsigned RAM_WORDS = 256
)
(
  input  logic       CLK,
  input  logic       RST,

  // Issue interface
  input  logic       op_vld,
  input  ls_op_t     op,
  input  logic       dir_vld,
  input  logic       dir_store,
  input  dreg_sel_t  dir_sel,
  input  word_t      dir_addr,

  // Host preload of the register banks
  input  logic       host_wr,
  input  logic       host_sel_ptr,
  input  dreg_sel_t  host_sel,
  input  word_t      host_data,

  // Peripheral side of the data bus
  output word_t      bus_addr,
  output logic       periph_sel,
  output logic       bus_wr,
  output byte_mask_t bus_mask,
  output word_t      bus_wdata,

  // Writeback observation
  output logic       load_vld,
  output dreg_sel_t  load_sel,
  output word_t      load_data,
  output logic       ptr_upd_vld,
  output preg_sel_t  ptr_upd_sel,
  output word_t      ptr_upd
);

  preg_sel_t ptr_sel;
  word_t     ptr;
  dreg_sel_t store_sel;
  word_t     store_data;
  logic      ram_cs;
  word_t     ram_rdata;

  ls_unit u_ls_unit (
    .CLK         (CLK),
    .RST         (RST),
    .op_vld      (op_vld),
    .op          (op),
    .dir_vld     (dir_vld),
    .dir_store   (dir_store),
    .dir_sel     (dir_sel),
    .dir_addr    (dir_addr),
    .ptr_sel     (ptr_sel),
    .ptr         (ptr),
    .store_sel   (store_sel),
    .store_data  (store_data),
    .ptr_upd_vld (ptr_upd_vld),
    .ptr_upd_sel (ptr_upd_sel),
    .ptr_upd     (ptr_upd),
    .load_vld    (load_vld),
    .load_sel    (load_sel),
    .load_data   (load_data),
    .bus_addr    (bus_addr),
    .ram_cs      (ram_cs),
    .periph_sel  (periph_sel),
    .bus_wr      (bus_wr),
    .bus_mask    (bus_mask),
    .bus_wdata   (bus_wdata),
    .ram_rdata   (ram_rdata)
  );

  register_file u_register_file (
    .CLK          (CLK),
    .RST          (RST),
    .ptr_sel      (ptr_sel),
    .ptr          (ptr),
    .store_sel    (store_sel),
    .store_data   (store_data),
    .ptr_upd_vld  (ptr_upd_vld),
    .ptr_upd_sel  (ptr_upd_sel),
    .ptr_upd      (ptr_upd),
    .load_vld     (load_vld),
    .load_sel     (load_sel),
    .load_data    (load_data),
    .host_wr      (host_wr),
    .host_sel_ptr (host_sel_ptr),
    .host_sel     (host_sel),
    .host_data    (host_data)
  );

  // The RAM sees the same bus as the peripheral space but only its own select
  data_ram #(
    .RAM_WORDS (RAM_WORDS)
  ) u_data_ram (
    .CLK       (CLK),
    .ram_cs    (ram_cs),
    .bus_wr    (bus_wr),
    .bus_mask  (bus_mask),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .ram_rdata (ram_rdata)
  );

endmodule

// ==== tb_checker.sv ====
// Testbench checker that mirrors registers, pointers and RAM from the issue inputs and compares outputs
module tb_checker
  import lsu_pkg::*;
#(
  parameter int unsigned RAM_WORDS = 256
)
(
  input  logic       CLK,
  input  logic       RST,
  input  logic       op_vld,
  input  ls_op_t     op,
  input  logic       dir_vld,
  input  logic       dir_store,
  input  dreg_sel_t  dir_sel,
  input  word_t      dir_addr,
  input  logic       host_wr,
  input  logic       host_sel_ptr,
  input  dreg_sel_t  host_sel,
  input  word_t      host_data,
  input  word_t      bus_addr,
  input  logic       periph_sel,
  input  logic       bus_wr,
  input  byte_mask_t bus_mask,
  input  word_t      bus_wdata,
  input  logic       load_vld,
  input  dreg_sel_t  load_sel,
  input  word_t      load_data,
  input  logic       ptr_upd_vld,
  input  preg_sel_t  ptr_upd_sel,
  input  word_t      ptr_upd,
  output logic       busy,
  output int         error_count,
  output int         check_count
);

  // Register and memory model, updated at issue time
  word_t      m_dreg [16];
  word_t      m_preg [8];
  word_t      m_mem  [RAM_WORDS];

  // What the bus and the pointer update must show one cycle after an issue
  logic       exp_acc;
  logic       exp_periph;
  logic       exp_wr;
  byte_mask_t exp_mask;
  word_t      exp_addr;
  word_t      exp_wdata;
  logic       exp_pv;
  preg_sel_t  exp_psel;
  word_t      exp_ptr;

  // Pending load writebacks, oldest first
  int         due_q  [$];
  dreg_sel_t  sel_q  [$];
  word_t      data_q [$];
  int         cyc;

  initial
  begin
    error_count = 0;
    check_count = 0;
  end

  task automatic compare(input string name, input word_t exp, input word_t act);
    check_count++;
    if (act !== exp)
    begin
      error_count++;
      $display("[FAIL] %s expected %h actual %h in cycle %0d", name, exp, act, cyc);
    end
  endtask

  task automatic clear_expect();
    exp_acc    = 1'b0;
    exp_periph = 1'b0;
    exp_wr     = 1'b0;
    exp_mask   = '0;
    exp_wdata  = '0;
    exp_pv     = 1'b0;
  endtask

  task automatic reset_model();
    for (int i = 0; i < 16; i++)
      m_dreg[i] = '0;
    for (int i = 0; i < 8; i++)
      m_preg[i] = '0;
    due_q.delete();
    sel_q.delete();
    data_q.delete();
    clear_expect();
    cyc = 0;
  endtask

  task automatic check_outputs();
    // Idle cycles expect all bus controls low and the write data zero
    compare("periph_sel", 32'(exp_periph), 32'(periph_sel));
    compare("bus_wr", 32'(exp_wr), 32'(bus_wr));
    compare("bus_mask", 32'(exp_mask), 32'(bus_mask));
    compare("bus_wdata", exp_wdata, bus_wdata);
    if (exp_acc)
      compare("bus_addr", exp_addr, bus_addr);
    compare("ptr_upd_vld", 32'(exp_pv), 32'(ptr_upd_vld));
    if (exp_pv)
    begin
      compare("ptr_upd_sel", 32'(exp_psel), 32'(ptr_upd_sel));
      compare("ptr_upd", exp_ptr, ptr_upd);
    end
    // A load whose slot has passed without load_vld is lost
    while (due_q.size() != 0 && due_q[0] < cyc)
    begin
      error_count++;
      $display("Expected load to register %0d never arrived (due in cycle %0d)",
               sel_q[0], due_q[0]);
      void'(due_q.pop_front());
      void'(sel_q.pop_front());
      void'(data_q.pop_front());
    end
    if (load_vld)
    begin
      if (due_q.size() == 0 || due_q[0] != cyc)
      begin
        error_count++;
        $display("load_vld fired for register %0d in cycle %0d with no load expected",
                 load_sel, cyc);
      end
      else
      begin
        compare("load_sel", 32'(sel_q[0]), 32'(load_sel));
        compare("load_data", data_q[0], load_data);
        void'(due_q.pop_front());
        void'(sel_q.pop_front());
        void'(data_q.pop_front());
      end
    end
    clear_expect();
  endtask

  task automatic apply_inputs();
    logic      st;
    logic      pm;
    int        size;
    int        ofs_s;
    int        adj;
    int        shift;
    int        idx;
    dreg_sel_t dsel;
    preg_sel_t psel;
    word_t     addr;
    word_t     d;
    word_t     rd;
    if (host_wr)
    begin
      if (host_sel_ptr)
        m_preg[host_sel[2:0]] = host_data;
      else
        m_dreg[host_sel] = host_data;
    end
    if (!(op_vld || dir_vld))
      return;
    if (dir_vld)
    begin
      st   = dir_store;
      size = 4;
      dsel = dir_sel;
      addr = dir_addr;
    end
    else
    begin
      st   = op[OP_STORE];
      pm   = op[OP_PMOD];
      size = op[OP_WORD] ? 4 : (op[OP_HALF] ? 2 : 1);
      dsel = {op[OP_WORD] & op[OP_HALF], op[OP_DREG_LSB +: OP_DREG_W]};
      psel = op[OP_PSEL_LSB +: OP_PSEL_W];
      // Signed offset only for pointer modify
      if (pm)
        ofs_s = $signed(op[OP_OFS_LSB +: OP_OFS_W]);
      else
        ofs_s = op[OP_OFS_LSB +: OP_OFS_W];
      adj  = ofs_s * size;
      addr = (pm && adj >= 0) ? m_preg[psel] : m_preg[psel] + adj;
      if (pm)
      begin
        exp_pv       = 1'b1;
        exp_psel     = psel;
        exp_ptr      = m_preg[psel] + adj;
        m_preg[psel] = exp_ptr;
      end
    end
    d          = m_dreg[dsel];
    exp_acc    = 1'b1;
    exp_periph = addr >= (32'd1 << PERIPH_LSB);
    exp_wr     = st;
    exp_addr   = addr & ~32'd3;
    // A lane is enabled when it sits in the same aligned group as the address
    for (int b = 0; b < 4; b++)
    begin
      exp_mask[b] = (b / size) == (int'(addr[1:0]) / size);
      exp_wdata[8*b +: 8] = st ? d[8*(b % size) +: 8] : 8'h00;
    end
    if (exp_periph)
      return;
    idx = (addr >> 2) % RAM_WORDS;
    if (st)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (exp_mask[b])
          m_mem[idx][8*b +: 8] = exp_wdata[8*b +: 8];
      end
    end
    else
    begin
      shift = (size == 4) ? 0 : (size == 2) ? 16 * int'(addr[1]) : 8 * int'(addr[1:0]);
      rd    = m_mem[idx] >> shift;
      if (size == 2)
        rd = rd & 32'h0000_ffff;
      else if (size == 1)
        rd = rd & 32'h0000_00ff;
      due_q.push_back(cyc + 3);
      sel_q.push_back(dsel);
      data_q.push_back(rd);
      m_dreg[dsel] = rd;
    end
  endtask

  // Falling edge sampling sees both the registered outputs and the delayed inputs settled
  always @(negedge CLK or posedge RST)
  begin
    if (RST)
      reset_model();
    else
    begin
      cyc++;
      check_outputs();
      apply_inputs();
    end
    busy = exp_acc || exp_pv || due_q.size() != 0;
  end

endmodule

// ==== tb_top.sv ====
// Testbench top that drives random load/store traffic into lsu_top and prints the final result
module tb_top
  import lsu_pkg::*;
();

  localparam int unsigned RAM_WORDS = 256;

  // Operation counts of the random tests
  localparam int N2 = 300;
  localparam int N3 = 150;
  localparam int N4 = 64;
  localparam int N5 = 400;

  // Cycle budget per test, including preloads and the final drain
  localparam int T1_CYC  = (RAM_WORDS / 16) * 40 + RAM_WORDS + 40;
  localparam int T2_CYC  = N2 + 40;
  localparam int T3_CYC  = N3 + 40;
  localparam int T4_CYC  = N4 + RAM_WORDS + 40;
  localparam int T5_CYC  = N5 + 40;
  localparam int MAX_CYC = 4 + T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC + 50;

  logic       CLK;
  logic       RST;
  logic       op_vld;
  ls_op_t     op;
  logic       dir_vld;
  logic       dir_store;
  dreg_sel_t  dir_sel;
  word_t      dir_addr;
  logic       host_wr;
  logic       host_sel_ptr;
  dreg_sel_t  host_sel;
  word_t      host_data;
  word_t      bus_addr;
  logic       periph_sel;
  logic       bus_wr;
  byte_mask_t bus_mask;
  word_t      bus_wdata;
  logic       load_vld;
  dreg_sel_t  load_sel;
  word_t      load_data;
  logic       ptr_upd_vld;
  preg_sel_t  ptr_upd_sel;
  word_t      ptr_upd;
  logic       chk_busy;
  int         err_cnt;
  int         chk_cnt;

  integer     seed = 1030;
  int         ptr_busy [8];
  int         dreg_busy [16];
  int         cycles;
  int         tests_run;
  int         tests_failed;
  int         err_start;
  word_t      fill_key;

  lsu_top #(
    .RAM_WORDS (RAM_WORDS)
  ) uut (
    .CLK          (CLK),
    .RST          (RST),
    .op_vld       (op_vld),
    .op           (op),
    .dir_vld      (dir_vld),
    .dir_store    (dir_store),
    .dir_sel      (dir_sel),
    .dir_addr     (dir_addr),
    .host_wr      (host_wr),
    .host_sel_ptr (host_sel_ptr),
    .host_sel     (host_sel),
    .host_data    (host_data),
    .bus_addr     (bus_addr),
    .periph_sel   (periph_sel),
    .bus_wr       (bus_wr),
    .bus_mask     (bus_mask),
    .bus_wdata    (bus_wdata),
    .load_vld     (load_vld),
    .load_sel     (load_sel),
    .load_data    (load_data),
    .ptr_upd_vld  (ptr_upd_vld),
    .ptr_upd_sel  (ptr_upd_sel),
    .ptr_upd      (ptr_upd)
  );

  // The checker sees the same inputs as the DUT and all of its outputs
  tb_checker #(
    .RAM_WORDS (RAM_WORDS)
  ) u_checker (
    .CLK          (CLK),
    .RST          (RST),
    .op_vld       (op_vld),
    .op           (op),
    .dir_vld      (dir_vld),
    .dir_store    (dir_store),
    .dir_sel      (dir_sel),
    .dir_addr     (dir_addr),
    .host_wr      (host_wr),
    .host_sel_ptr (host_sel_ptr),
    .host_sel     (host_sel),
    .host_data    (host_data),
    .bus_addr     (bus_addr),
    .periph_sel   (periph_sel),
    .bus_wr       (bus_wr),
    .bus_mask     (bus_mask),
    .bus_wdata    (bus_wdata),
    .load_vld     (load_vld),
    .load_sel     (load_sel),
    .load_data    (load_data),
    .ptr_upd_vld  (ptr_upd_vld),
    .ptr_upd_sel  (ptr_upd_sel),
    .ptr_upd      (ptr_upd),
    .busy         (chk_busy),
    .error_count  (err_cnt),
    .check_count  (chk_cnt)
  );

  always #50 CLK = ~CLK;

  // Hard stop once the run is longer than all tests together
  always @(posedge CLK)
  begin
    cycles++;
    if (cycles >= MAX_CYC)
    begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYC);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // Inputs change shortly after the rising edge and fall back to idle every cycle
  task automatic next_cycle();
    @(posedge CLK);
    #10;
    op_vld  = 1'b0;
    dir_vld = 1'b0;
    host_wr = 1'b0;
    for (int i = 0; i < 16; i++)
    begin
      if (dreg_busy[i] > 0)
        dreg_busy[i]--;
    end
    for (int i = 0; i < 8; i++)
    begin
      if (ptr_busy[i] > 0)
        ptr_busy[i]--;
    end
  endtask

  function automatic ls_op_t make_op(input logic st, input logic pm, input logic [1:0] size,
                                     input logic [4:0] ofs, input preg_sel_t psel,
                                     input logic [2:0] dreg);
    ls_op_t o;
    o = '0;
    o[OP_STORE] = st;
    o[OP_PMOD]  = pm;
    // Size 0 is byte, 1 half, 2 word and 3 word on the upper data registers
    o[OP_WORD]  = size[1];
    o[OP_HALF]  = size[0];
    o[OP_OFS_LSB +: OP_OFS_W]   = ofs;
    o[OP_PSEL_LSB +: OP_PSEL_W] = psel;
    o[OP_DREG_LSB +: OP_DREG_W] = dreg;
    return o;
  endfunction

  // An operation that would read a register still being updated becomes an idle cycle
  task automatic send_op(input ls_op_t o);
    dreg_sel_t d;
    preg_sel_t p;
    d = {o[OP_WORD] & o[OP_HALF], o[OP_DREG_LSB +: OP_DREG_W]};
    p = o[OP_PSEL_LSB +: OP_PSEL_W];
    next_cycle();
    if (ptr_busy[p] == 0 && dreg_busy[d] == 0)
    begin
      op_vld = 1'b1;
      op     = o;
      if (o[OP_PMOD])
        ptr_busy[p] = 2;
      if (!o[OP_STORE])
        dreg_busy[d] = 4;
    end
  endtask

  task automatic send_dir(input logic st, input dreg_sel_t sel, input word_t addr);
    next_cycle();
    if (dreg_busy[sel] == 0)
    begin
      dir_vld   = 1'b1;
      dir_store = st;
      dir_sel   = sel;
      dir_addr  = addr;
      if (!st)
        dreg_busy[sel] = 4;
    end
  endtask

  // Mode 0 never modifies the pointer, 1 always does, 2 picks at random
  task automatic send_random(input int pmod_mode);
    logic pm;
    pm = (pmod_mode == 2) ? $random(seed) : pmod_mode[0];
    send_op(make_op($random(seed), pm, $random(seed), $random(seed), $random(seed),
                    $random(seed)));
  endtask

  task automatic host_load(input logic to_ptr, input dreg_sel_t sel, input word_t data);
    next_cycle();
    host_wr      = 1'b1;
    host_sel_ptr = to_ptr;
    host_sel     = sel;
    host_data    = data;
  endtask

  // Idle until the checker has nothing outstanding
  task automatic drain();
    do
      next_cycle();
    while (chk_busy);
  endtask

  task automatic end_test(input string name);
    drain();
    tests_run++;
    if (err_cnt != err_start)
      tests_failed++;
    $display("Test %0d (%s) done with %0d errors", tests_run, name, err_cnt - err_start);
    err_start = err_cnt;
  endtask

  // RAM fill value that differs in every word of the array
  function automatic word_t fill_word(input int w);
    return {~w[15:0], w[15:0]} ^ fill_key;
  endfunction

  initial
  begin
    CLK          = 1'b0;
    RST          = 1'b1;
    op_vld       = 1'b0;
    op           = '0;
    dir_vld      = 1'b0;
    dir_store    = 1'b0;
    dir_sel      = '0;
    dir_addr     = '0;
    host_wr      = 1'b0;
    host_sel_ptr = 1'b0;
    host_sel     = '0;
    host_data    = '0;
    cycles       = 0;
    tests_run    = 0;
    tests_failed = 0;
    err_start    = 0;
    for (int i = 0; i < 16; i++)
      dreg_busy[i] = 0;
    for (int i = 0; i < 8; i++)
      ptr_busy[i] = 0;
    repeat (4) @(posedge CLK);
    #10;
    RST = 1'b0;

    // Fill the whole RAM in batches of 16 words and read every word back
    fill_key = $random(seed);
    for (int b = 0; b < RAM_WORDS / 16; b++)
    begin
      for (int r = 0; r < 16; r++)
        host_load(1'b0, r, fill_word(b * 16 + r));
      for (int r = 0; r < 16; r++)
        send_dir(1'b1, r, (b * 16 + r) * 4);
      drain();
    end
    for (int w = 0; w < RAM_WORDS; w++)
      send_dir(1'b0, w % 16, w * 4);
    end_test("reset and direct word fill");

    // Pointers leave room for the largest unsigned word offset
    for (int r = 0; r < 16; r++)
      host_load(1'b0, r, $random(seed));
    for (int p = 0; p < 8; p++)
      host_load(1'b1, p, $unsigned($random(seed)) % (RAM_WORDS * 4 - 128));
    for (int i = 0; i < N2; i++)
      send_random(0);
    end_test("unsigned offset byte, half and word");

    for (int p = 0; p < 8; p++)
      host_load(1'b1, p, RAM_WORDS * 2 + $unsigned($random(seed)) % 64);
    for (int i = 0; i < N3; i++)
      send_random(1);
    end_test("pointer modify");

    // Pointers far enough below the top that an offset cannot wrap into RAM space
    for (int p = 0; p < 8; p++)
      host_load(1'b1, p, 32'h0010_0000 | ($random(seed) & 32'h0fff_ffff));
    for (int i = 0; i < N4; i++)
    begin
      if ($random(seed) & 1)
        send_random(0);
      else
        send_dir($random(seed), $random(seed), 32'h0010_0000 | ($random(seed) & 32'h0fff_ffff));
    end
    drain();
    // Every RAM word must still hold what the model last stored there
    for (int w = 0; w < RAM_WORDS; w++)
      send_dir(1'b0, w % 16, w * 4);
    end_test("peripheral space");

    for (int p = 0; p < 8; p++)
      host_load(1'b1, p, 128 + $unsigned($random(seed)) % (RAM_WORDS * 4 - 256));
    for (int i = 0; i < N5; i++)
      send_random(2);
    end_test("back-to-back mixed traffic");

    $display("Tests run %0d, tests failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, chk_cnt, err_cnt);
    if (tests_failed == 0 && err_cnt == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== tb.f ====
lsu_pkg.sv
data_ram.sv
register_file.sv
ls_unit.sv
lsu_top.sv
tb_checker.sv
tb_top.sv
